/* source/mem_unit_cfg.svh */
`ifndef MEM_UNIT_CFG_SVH
`define MEM_UNIT_CFG_SVH

// Core side word format
`define MEM_ADDR_WIDTH      32
`define MEM_WORD_WIDTH      32
`define MEM_BYTEEN_WIDTH    4
`define MEM_TAG_WIDTH       4

// Core tag plus the arbiter source bit in the LSB
`define DRAM_TAG_WIDTH      5

// Scratchpad window byte address and depth in words
`define SMEM_BASE           32'h0001_0000
`define SMEM_WORDS          256

// I/O space runs from here to the top of the address map
`define IO_BASE             32'hFF00_0000

// Performance counters
`define PERF_WIDTH          64

`endif

/* source/mem_unit_pkg.sv */
`include "mem_unit_cfg.svh"

package mem_unit_pkg;

    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_e;

    // Values double as bit positions in the router's per-target vectors
    typedef enum logic [1:0] {
        TARGET_DRAM = 2'd0,
        TARGET_SMEM = 2'd1,
        TARGET_IO   = 2'd2
    } mem_target_e;

    typedef struct packed {
        mem_op_e                      op;
        logic [`MEM_ADDR_WIDTH-1:0]   addr;
        logic [`MEM_BYTEEN_WIDTH-1:0] byteen;
        logic [`MEM_WORD_WIDTH-1:0]   data;
        logic [`MEM_TAG_WIDTH-1:0]    tag;
    } core_req_t;

    typedef struct packed {
        logic [`MEM_WORD_WIDTH-1:0] data;
        logic [`MEM_TAG_WIDTH-1:0]  tag;
    } core_rsp_t;

    typedef struct packed {
        mem_op_e                      op;
        logic [`MEM_ADDR_WIDTH-1:0]   addr;
        logic [`MEM_BYTEEN_WIDTH-1:0] byteen;
        logic [`MEM_WORD_WIDTH-1:0]   data;
        logic [`DRAM_TAG_WIDTH-1:0]   tag;
    } dram_req_t;

    typedef struct packed {
        logic [`MEM_WORD_WIDTH-1:0] data;
        logic [`DRAM_TAG_WIDTH-1:0] tag;
    } dram_rsp_t;

    typedef struct packed {
        logic [`PERF_WIDTH-1:0] requests;
        logic [`PERF_WIDTH-1:0] responses;
        logic [`PERF_WIDTH-1:0] latency;
    } perf_cnt_t;

endpackage

/* source/data_router.sv */
`timescale 1ns/1ns
`include "mem_unit_cfg.svh"

module data_router (
    input  logic                    clk,
    input  logic                    reset,

    input  logic                    core_req_valid,
    input  mem_unit_pkg::core_req_t core_req,
    output logic                    core_req_ready,
    output logic                    core_rsp_valid,
    output mem_unit_pkg::core_rsp_t core_rsp,
    input  logic                    core_rsp_ready,

    output logic                    smem_req_valid,
    output mem_unit_pkg::core_req_t smem_req,
    input  logic                    smem_req_ready,
    input  logic                    smem_rsp_valid,
    input  mem_unit_pkg::core_rsp_t smem_rsp,
    output logic                    smem_rsp_ready,

    output logic                    io_req_valid,
    output mem_unit_pkg::core_req_t io_req,
    input  logic                    io_req_ready,
    input  logic                    io_rsp_valid,
    input  mem_unit_pkg::core_rsp_t io_rsp,
    output logic                    io_rsp_ready,

    output logic                    dram_req_valid,
    output mem_unit_pkg::core_req_t dram_req,
    input  logic                    dram_req_ready,
    input  logic                    dram_rsp_valid,
    input  mem_unit_pkg::core_rsp_t dram_rsp,
    output logic                    dram_rsp_ready
);
    localparam logic [`MEM_ADDR_WIDTH-1:0] SMEM_END =
        `SMEM_BASE + `MEM_BYTEEN_WIDTH * `SMEM_WORDS;

    mem_unit_pkg::mem_target_e target;
    logic [2:0] read_issue;
    logic [2:0] tgt_rsp_valid;
    logic [2:0] tgt_rsp_fire;

    always_comb begin
        if (core_req.addr >= `IO_BASE) begin
            target = mem_unit_pkg::TARGET_IO;
        end else if (core_req.addr >= `SMEM_BASE && core_req.addr < SMEM_END) begin
            target = mem_unit_pkg::TARGET_SMEM;
        end else begin
            target = mem_unit_pkg::TARGET_DRAM;
        end
    end

    // Same payload fans out and only the selected valid goes high
    assign smem_req = core_req;
    assign io_req   = core_req;
    assign dram_req = core_req;

    assign smem_req_valid = core_req_valid && target == mem_unit_pkg::TARGET_SMEM;
    assign io_req_valid   = core_req_valid && target == mem_unit_pkg::TARGET_IO;
    assign dram_req_valid = core_req_valid && target == mem_unit_pkg::TARGET_DRAM;

    always_comb begin
        case (target)
            mem_unit_pkg::TARGET_SMEM: core_req_ready = smem_req_ready;
            mem_unit_pkg::TARGET_IO:   core_req_ready = io_req_ready;
            default:                   core_req_ready = dram_req_ready;
        endcase
    end

    // Fixed priority of scratchpad over I/O over DRAM
    assign smem_rsp_ready = core_rsp_ready;
    assign io_rsp_ready   = core_rsp_ready && !smem_rsp_valid;
    assign dram_rsp_ready = core_rsp_ready && !smem_rsp_valid && !io_rsp_valid;

    assign core_rsp_valid = smem_rsp_valid || io_rsp_valid || dram_rsp_valid;
    assign core_rsp = smem_rsp_valid ? smem_rsp : (io_rsp_valid ? io_rsp : dram_rsp);

    // Bookkeeping of reads sent to each target
    always_comb begin
        read_issue = '0;
        if (core_req_valid && core_req_ready && core_req.op == mem_unit_pkg::MEM_READ) begin
            read_issue[target] = 1'b1;
        end
    end

    assign tgt_rsp_valid = {io_rsp_valid, smem_rsp_valid, dram_rsp_valid};
    assign tgt_rsp_fire  = {io_rsp_valid && io_rsp_ready,
                            smem_rsp_valid && smem_rsp_ready,
                            dram_rsp_valid && dram_rsp_ready};

    for (genvar i = 0; i < 3; i++) begin : g_pending
        logic [7:0] count;

        always_ff @(posedge clk) begin
            if (reset) begin
                count <= '0;
            end else begin
                count <= count + 8'(read_issue[i]) - 8'(tgt_rsp_fire[i]);
            end
        end

        // Writes are silent, so a response needs an earlier read
        assert property (@(posedge clk) disable iff (reset)
            tgt_rsp_valid[i] |-> (count != 0 || read_issue[i]))
            else $error("response from target %0d with no read outstanding", i);
    end

endmodule

/* source/shared_mem.sv */
`timescale 1ns/1ns
`include "mem_unit_cfg.svh"

module shared_mem (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    req_valid,
    input  mem_unit_pkg::core_req_t req,
    output logic                    req_ready,
    output logic                    rsp_valid,
    output mem_unit_pkg::core_rsp_t rsp,
    input  logic                    rsp_ready
);
    localparam int IDX_WIDTH = $clog2(`SMEM_WORDS);
    localparam int OFF_WIDTH = $clog2(`MEM_BYTEEN_WIDTH);

    logic [`MEM_WORD_WIDTH-1:0] mem [`SMEM_WORDS];
    logic [IDX_WIDTH-1:0] idx;
    logic req_fire;
    logic read_fire;
    logic write_fire;

    // Window is aligned, so the word bits index directly
    assign idx = req.addr[OFF_WIDTH +: IDX_WIDTH];

    assign req_ready  = !rsp_valid || rsp_ready;
    assign req_fire   = req_valid && req_ready;
    assign read_fire  = req_fire && req.op == mem_unit_pkg::MEM_READ;
    assign write_fire = req_fire && req.op == mem_unit_pkg::MEM_WRITE;

    always_ff @(posedge clk) begin
        if (write_fire) begin
            for (int b = 0; b < `MEM_BYTEEN_WIDTH; b++) begin
                if (req.byteen[b]) begin
                    mem[idx][b*8 +: 8] <= req.data[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else if (read_fire) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    // Holds under back-pressure since no read is accepted then
    always_ff @(posedge clk) begin
        if (read_fire) begin
            rsp.data <= mem[idx];
            rsp.tag  <= req.tag;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        req_valid && !req_ready |=> req_valid && $stable(req))
        else $error("scratchpad request changed while stalled");

endmodule

/* source/dram_arb.sv */
`timescale 1ns/1ns
`include "mem_unit_cfg.svh"

module dram_arb (
    input  logic                    clk,
    input  logic                    reset,

    input  logic                    ifetch_req_valid,
    input  mem_unit_pkg::core_req_t ifetch_req,
    output logic                    ifetch_req_ready,
    output logic                    ifetch_rsp_valid,
    output mem_unit_pkg::core_rsp_t ifetch_rsp,
    input  logic                    ifetch_rsp_ready,

    input  logic                    data_req_valid,
    input  mem_unit_pkg::core_req_t data_req,
    output logic                    data_req_ready,
    output logic                    data_rsp_valid,
    output mem_unit_pkg::core_rsp_t data_rsp,
    input  logic                    data_rsp_ready,

    output logic                    dram_req_valid,
    output mem_unit_pkg::dram_req_t dram_req,
    input  logic                    dram_req_ready,
    input  logic                    dram_rsp_valid,
    input  mem_unit_pkg::dram_rsp_t dram_rsp,
    output logic                    dram_rsp_ready
);
    logic last_data;
    logic sel_data;
    logic out_ready;
    logic req_fire;
    logic rsp_is_data;
    mem_unit_pkg::core_req_t sel_req;

    assign out_ready = !dram_req_valid || dram_req_ready;

    // Data wins when alone, or when fetch was granted last
    assign sel_data = data_req_valid && (!ifetch_req_valid || !last_data);
    assign sel_req  = sel_data ? data_req : ifetch_req;

    assign ifetch_req_ready = out_ready && !sel_data;
    assign data_req_ready   = out_ready && sel_data;
    assign req_fire = out_ready && (ifetch_req_valid || data_req_valid);

    always_ff @(posedge clk) begin
        if (reset) begin
            dram_req_valid <= 1'b0;
            last_data      <= 1'b0;
        end else if (req_fire) begin
            dram_req_valid <= 1'b1;
            last_data      <= sel_data;
        end else if (dram_req_ready) begin
            dram_req_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            dram_req.op     <= sel_req.op;
            dram_req.addr   <= sel_req.addr;
            dram_req.byteen <= sel_req.byteen;
            dram_req.data   <= sel_req.data;
            dram_req.tag    <= {sel_req.tag, sel_data};
        end
    end

    // Return path steered by the source bit in the tag LSB
    assign rsp_is_data = dram_rsp.tag[0];

    assign ifetch_rsp_valid = dram_rsp_valid && !rsp_is_data;
    assign data_rsp_valid   = dram_rsp_valid && rsp_is_data;

    assign ifetch_rsp.data = dram_rsp.data;
    assign ifetch_rsp.tag  = dram_rsp.tag[`DRAM_TAG_WIDTH-1:1];
    assign data_rsp.data   = dram_rsp.data;
    assign data_rsp.tag    = dram_rsp.tag[`DRAM_TAG_WIDTH-1:1];

    assign dram_rsp_ready = rsp_is_data ? data_rsp_ready : ifetch_rsp_ready;

    // Fetch side is read only all the way out to DRAM
    assert property (@(posedge clk) disable iff (reset)
        dram_req_valid && !dram_req.tag[0] |-> dram_req.op == mem_unit_pkg::MEM_READ)
        else $error("fetch request issued to DRAM as a write");

endmodule

/* source/dram_perf.sv */
`timescale 1ns/1ns
`include "mem_unit_cfg.svh"

module dram_perf (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    dram_req_valid,
    input  logic                    dram_req_ready,
    input  mem_unit_pkg::mem_op_e   dram_req_op,
    input  logic                    dram_rsp_valid,
    input  logic                    dram_rsp_ready,
    output mem_unit_pkg::perf_cnt_t perf
);
    localparam int CW = `PERF_WIDTH;

    logic [CW-1:0] outstanding;
    logic req_fire;
    logic read_fire;
    logic rsp_fire;

    assign req_fire  = dram_req_valid && dram_req_ready;
    assign read_fire = req_fire && dram_req_op == mem_unit_pkg::MEM_READ;
    assign rsp_fire  = dram_rsp_valid && dram_rsp_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            outstanding <= '0;
            perf        <= '0;
        end else begin
            if (req_fire) begin
                perf.requests <= perf.requests + CW'(1);
            end
            if (rsp_fire) begin
                perf.responses <= perf.responses + CW'(1);
            end
            // Each cycle a read waits adds one to latency
            perf.latency <= perf.latency + outstanding;
            outstanding  <= outstanding + CW'(read_fire) - CW'(rsp_fire);
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        rsp_fire |-> outstanding != 0)
        else $error("DRAM response with no read outstanding");

endmodule

/* source/mem_unit.sv */
`timescale 1ns/1ns

module mem_unit (
    input  logic                    clk,
    input  logic                    reset,

    input  logic                    ifetch_req_valid,
    input  mem_unit_pkg::core_req_t ifetch_req,
    output logic                    ifetch_req_ready,
    output logic                    ifetch_rsp_valid,
    output mem_unit_pkg::core_rsp_t ifetch_rsp,
    input  logic                    ifetch_rsp_ready,

    input  logic                    data_req_valid,
    input  mem_unit_pkg::core_req_t data_req,
    output logic                    data_req_ready,
    output logic                    data_rsp_valid,
    output mem_unit_pkg::core_rsp_t data_rsp,
    input  logic                    data_rsp_ready,

    output logic                    io_req_valid,
    output mem_unit_pkg::core_req_t io_req,
    input  logic                    io_req_ready,
    input  logic                    io_rsp_valid,
    input  mem_unit_pkg::core_rsp_t io_rsp,
    output logic                    io_rsp_ready,

    output logic                    dram_req_valid,
    output mem_unit_pkg::dram_req_t dram_req,
    input  logic                    dram_req_ready,
    input  logic                    dram_rsp_valid,
    input  mem_unit_pkg::dram_rsp_t dram_rsp,
    output logic                    dram_rsp_ready,

    output mem_unit_pkg::perf_cnt_t perf
);
    logic                    smem_req_valid;
    mem_unit_pkg::core_req_t smem_req;
    logic                    smem_req_ready;
    logic                    smem_rsp_valid;
    mem_unit_pkg::core_rsp_t smem_rsp;
    logic                    smem_rsp_ready;

    // Data side DRAM traffic between router and arbiter
    logic                    data_dram_req_valid;
    mem_unit_pkg::core_req_t data_dram_req;
    logic                    data_dram_req_ready;
    logic                    data_dram_rsp_valid;
    mem_unit_pkg::core_rsp_t data_dram_rsp;
    logic                    data_dram_rsp_ready;

    data_router data_router_inst (
        .clk            (clk),
        .reset          (reset),
        .core_req_valid (data_req_valid),
        .core_req       (data_req),
        .core_req_ready (data_req_ready),
        .core_rsp_valid (data_rsp_valid),
        .core_rsp       (data_rsp),
        .core_rsp_ready (data_rsp_ready),
        .smem_req_valid (smem_req_valid),
        .smem_req       (smem_req),
        .smem_req_ready (smem_req_ready),
        .smem_rsp_valid (smem_rsp_valid),
        .smem_rsp       (smem_rsp),
        .smem_rsp_ready (smem_rsp_ready),
        .io_req_valid   (io_req_valid),
        .io_req         (io_req),
        .io_req_ready   (io_req_ready),
        .io_rsp_valid   (io_rsp_valid),
        .io_rsp         (io_rsp),
        .io_rsp_ready   (io_rsp_ready),
        .dram_req_valid (data_dram_req_valid),
        .dram_req       (data_dram_req),
        .dram_req_ready (data_dram_req_ready),
        .dram_rsp_valid (data_dram_rsp_valid),
        .dram_rsp       (data_dram_rsp),
        .dram_rsp_ready (data_dram_rsp_ready)
    );

    shared_mem shared_mem_inst (
        .clk       (clk),
        .reset     (reset),
        .req_valid (smem_req_valid),
        .req       (smem_req),
        .req_ready (smem_req_ready),
        .rsp_valid (smem_rsp_valid),
        .rsp       (smem_rsp),
        .rsp_ready (smem_rsp_ready)
    );

    dram_arb dram_arb_inst (
        .clk              (clk),
        .reset            (reset),
        .ifetch_req_valid (ifetch_req_valid),
        .ifetch_req       (ifetch_req),
        .ifetch_req_ready (ifetch_req_ready),
        .ifetch_rsp_valid (ifetch_rsp_valid),
        .ifetch_rsp       (ifetch_rsp),
        .ifetch_rsp_ready (ifetch_rsp_ready),
        .data_req_valid   (data_dram_req_valid),
        .data_req         (data_dram_req),
        .data_req_ready   (data_dram_req_ready),
        .data_rsp_valid   (data_dram_rsp_valid),
        .data_rsp         (data_dram_rsp),
        .data_rsp_ready   (data_dram_rsp_ready),
        .dram_req_valid   (dram_req_valid),
        .dram_req         (dram_req),
        .dram_req_ready   (dram_req_ready),
        .dram_rsp_valid   (dram_rsp_valid),
        .dram_rsp         (dram_rsp),
        .dram_rsp_ready   (dram_rsp_ready)
    );

    dram_perf dram_perf_inst (
        .clk            (clk),
        .reset          (reset),
        .dram_req_valid (dram_req_valid),
        .dram_req_ready (dram_req_ready),
        .dram_req_op    (dram_req.op),
        .dram_rsp_valid (dram_rsp_valid),
        .dram_rsp_ready (dram_rsp_ready),
        .perf           (perf)
    );

endmodule

/* bench/mem_unit_tb.sv */
`timescale 1ns/1ns
`include "mem_unit_cfg.svh"

module mem_unit_tb;
    localparam int LIMIT = 2000;

    logic clk = 1'b0;
    logic reset;
    logic bp;
    logic [31:0] lfsr_state;

    logic ifetch_req_valid, ifetch_req_ready, ifetch_rsp_valid, ifetch_rsp_ready;
    logic data_req_valid, data_req_ready, data_rsp_valid, data_rsp_ready;
    logic io_req_valid, io_req_ready, io_rsp_valid, io_rsp_ready;
    logic dram_req_valid, dram_req_ready, dram_rsp_valid, dram_rsp_ready;
    mem_unit_pkg::core_req_t ifetch_req, data_req, io_req;
    mem_unit_pkg::core_rsp_t ifetch_rsp, data_rsp, io_rsp;
    mem_unit_pkg::dram_req_t dram_req;
    mem_unit_pkg::dram_rsp_t dram_rsp;
    mem_unit_pkg::perf_cnt_t perf;

    // Reference state
    logic [31:0] shadow [16];
    bit data_out [16];
    bit fetch_out [16];
    logic [31:0] data_exp [16];
    logic [31:0] fetch_exp [16];
    logic [3:0] data_tag, fetch_tag, smem_tag_q;
    logic [63:0] cnt_req, cnt_rsp, dram_pending, lat_sum;
    logic last_data_q, granted_once;
    mem_unit_pkg::core_req_t io_q [$];
    mem_unit_pkg::dram_req_t dram_q [$];
    mem_unit_pkg::dram_req_t dram_exp;

    mem_unit_pkg::mem_target_e data_region;
    logic data_fire, data_dram_valid, data_dram_fire, ifetch_fire, smem_read_fire;
    logic [31:0] data_rsp_exp, fetch_rsp_exp;

    mem_unit mem_unit_inst (.*);

    always #5 clk = ~clk;

    function automatic mem_unit_pkg::mem_target_e region_of(input logic [31:0] addr);
        if (addr >= `IO_BASE) begin
            return mem_unit_pkg::TARGET_IO;
        end
        if (addr >= `SMEM_BASE && addr < `SMEM_BASE + 4 * `SMEM_WORDS) begin
            return mem_unit_pkg::TARGET_SMEM;
        end
        return mem_unit_pkg::TARGET_DRAM;
    endfunction

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    task automatic fail_value(input string name, input logic [127:0] exp,
                              input logic [127:0] act);
        $display("** Error %s expected %h actual %h", name, exp, act);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic fail_msg(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1);
    endtask

    assign data_region     = region_of(data_req.addr);
    assign data_fire       = data_req_valid && data_req_ready;
    assign data_dram_valid = data_req_valid && data_region == mem_unit_pkg::TARGET_DRAM;
    assign data_dram_fire  = data_dram_valid && data_req_ready;
    assign ifetch_fire     = ifetch_req_valid && ifetch_req_ready;
    assign smem_read_fire  = data_fire && data_region == mem_unit_pkg::TARGET_SMEM
                             && data_req.op == mem_unit_pkg::MEM_READ;
    assign data_rsp_exp    = data_exp[data_rsp.tag];
    assign fetch_rsp_exp   = fetch_exp[ifetch_rsp.tag];

    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 16; i++) begin
                data_out[i]  <= 1'b0;
                fetch_out[i] <= 1'b0;
            end
            {cnt_req, cnt_rsp, dram_pending, lat_sum} <= '0;
            last_data_q  <= 1'b0;
            granted_once <= 1'b0;
        end else begin
            if (data_rsp_valid && data_rsp_ready) data_out[data_rsp.tag] <= 1'b0;
            if (ifetch_rsp_valid && ifetch_rsp_ready) fetch_out[ifetch_rsp.tag] <= 1'b0;
            if (data_fire && data_req.op == mem_unit_pkg::MEM_READ) begin
                data_out[data_req.tag] <= 1'b1;
                case (data_region)
                    mem_unit_pkg::TARGET_SMEM: data_exp[data_req.tag] <= shadow[data_req.addr[5:2]];
                    mem_unit_pkg::TARGET_IO:   data_exp[data_req.tag] <= data_req.addr + 32'd1;
                    default: data_exp[data_req.tag] <= data_req.addr ^ 32'h5A5A_5A5A;
                endcase
            end
            if (data_fire && data_region == mem_unit_pkg::TARGET_SMEM
                    && data_req.op == mem_unit_pkg::MEM_WRITE) begin
                for (int b = 0; b < 4; b++) begin
                    if (data_req.byteen[b]) begin
                        shadow[data_req.addr[5:2]][b*8 +: 8] <= data_req.data[b*8 +: 8];
                    end
                end
            end
            if (ifetch_fire) begin
                fetch_out[ifetch_req.tag] <= 1'b1;
                fetch_exp[ifetch_req.tag] <= ifetch_req.addr ^ 32'h5A5A_5A5A;
            end
            if (ifetch_fire || data_dram_fire) begin
                last_data_q  <= data_dram_fire;
                granted_once <= 1'b1;
                dram_exp     <= data_dram_fire ? {data_req, 1'b1} : {ifetch_req, 1'b0};
            end
            if (dram_req_valid && dram_req_ready) cnt_req <= cnt_req + 64'd1;
            if (dram_rsp_valid && dram_rsp_ready) cnt_rsp <= cnt_rsp + 64'd1;
            lat_sum <= lat_sum + dram_pending;
            dram_pending <= dram_pending
                + 64'(dram_req_valid && dram_req_ready && dram_req.op == mem_unit_pkg::MEM_READ)
                - 64'(dram_rsp_valid && dram_rsp_ready);
        end
        if (smem_read_fire) smem_tag_q <= data_req.tag;
    end

    assert property (@(posedge clk) $fell(reset) |-> !dram_req_valid && !io_req_valid
        && !data_rsp_valid && !ifetch_rsp_valid && perf == '0)
        else fail_msg("outputs or counters not cleared by reset");
    assert property (@(posedge clk) disable iff (reset)
        smem_read_fire |=> data_rsp_valid && data_rsp.tag == smem_tag_q)
        else fail_value("smem_latency", $sampled(smem_tag_q), $sampled(data_rsp.tag));
    assert property (@(posedge clk) disable iff (reset)
        data_req_valid && data_region == mem_unit_pkg::TARGET_IO
        |-> io_req_valid && io_req == data_req)
        else fail_value("io_request", $sampled(data_req.addr), $sampled(io_req.addr));
    assert property (@(posedge clk) disable iff (reset)
        data_rsp_valid && data_rsp_ready |-> data_out[data_rsp.tag])
        else fail_msg("data response with no read outstanding for its tag");
    assert property (@(posedge clk) disable iff (reset)
        data_rsp_valid && data_rsp_ready |-> data_rsp.data == data_rsp_exp)
        else fail_value("data_response", $sampled(data_rsp_exp), $sampled(data_rsp.data));
    assert property (@(posedge clk) disable iff (reset)
        ifetch_rsp_valid && ifetch_rsp_ready |-> fetch_out[ifetch_rsp.tag])
        else fail_msg("fetch response with no read outstanding for its tag");
    assert property (@(posedge clk) disable iff (reset)
        ifetch_rsp_valid && ifetch_rsp_ready |-> ifetch_rsp.data == fetch_rsp_exp)
        else fail_value("fetch_response", $sampled(fetch_rsp_exp), $sampled(ifetch_rsp.data));
    assert property (@(posedge clk) disable iff (reset)
        ifetch_req_valid && data_dram_valid && (ifetch_fire || data_dram_fire) && granted_once
        |-> data_dram_fire != last_data_q)
        else fail_value("round_robin", $sampled(!last_data_q), $sampled(data_dram_fire));
    assert property (@(posedge clk) disable iff (reset)
        dram_req_valid |-> dram_req == dram_exp)
        else fail_value("dram_request", $sampled(dram_exp), $sampled(dram_req));
    assert property (@(posedge clk) disable iff (reset)
        dram_req_valid && !dram_req_ready |=> dram_req_valid && $stable(dram_req))
        else fail_msg("DRAM request changed while stalled");
    assert property (@(posedge clk) disable iff (reset) perf.requests == cnt_req)
        else fail_value("perf_requests", $sampled(cnt_req), $sampled(perf.requests));
    assert property (@(posedge clk) disable iff (reset) perf.responses == cnt_rsp)
        else fail_value("perf_responses", $sampled(cnt_rsp), $sampled(perf.responses));
    assert property (@(posedge clk) disable iff (reset) perf.latency == lat_sum)
        else fail_value("perf_latency", $sampled(lat_sum), $sampled(perf.latency));

    // I/O target answering in order after a random gap
    always begin : io_model
        logic take, done;
        logic [31:0] r;
        mem_unit_pkg::core_req_t req_c;
        @(posedge clk);
        take  = io_req_valid && io_req_ready && io_req.op == mem_unit_pkg::MEM_READ;
        done  = io_rsp_valid && io_rsp_ready;
        req_c = io_req;
        #1;
        if (done) begin
            void'(io_q.pop_front());
            io_rsp_valid = 1'b0;
        end
        if (take) io_q.push_back(req_c);
        rand_bits(2, r);
        if (!io_rsp_valid && io_q.size() > 0 && r[1:0] != 2'd0) begin
            io_rsp_valid = 1'b1;
            io_rsp.data  = io_q[0].addr + 32'd1;
            io_rsp.tag   = io_q[0].tag;
        end
        rand_bits(1, r);
        io_req_ready = !bp || r[0];
    end

    always begin : dram_model
        logic take, done;
        logic [31:0] r;
        int delay;
        mem_unit_pkg::dram_req_t req_c;
        @(posedge clk);
        take  = dram_req_valid && dram_req_ready && dram_req.op == mem_unit_pkg::MEM_READ;
        done  = dram_rsp_valid && dram_rsp_ready;
        req_c = dram_req;
        #1;
        if (done) begin
            void'(dram_q.pop_front());
            dram_rsp_valid = 1'b0;
        end
        if (take) dram_q.push_back(req_c);
        if (!dram_rsp_valid && dram_q.size() > 0) begin
            if (delay <= 0) begin
                dram_rsp_valid = 1'b1;
                dram_rsp.data  = dram_q[0].addr ^ 32'h5A5A_5A5A;
                dram_rsp.tag   = dram_q[0].tag;
                rand_bits(2, r);
                delay = int'(r[1:0]);
            end else begin
                delay--;
            end
        end
        rand_bits(3, r);
        dram_req_ready   = !bp || r[0];
        data_rsp_ready   = !bp || r[1];
        ifetch_rsp_ready = !bp || r[2];
    end

    task automatic issue_req(input bit fetch, input mem_unit_pkg::mem_op_e op,
                             input logic [31:0] addr, input logic [3:0] be, input logic [31:0] wd);
        int waited;
        logic [3:0] tag;
        mem_unit_pkg::core_req_t req;
        waited = 0;
        tag = fetch ? fetch_tag : data_tag;
        while (op == mem_unit_pkg::MEM_READ && (fetch ? fetch_out[tag] : data_out[tag])) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > LIMIT) fail_msg("read tag never became free");
        end
        if (fetch) fetch_tag = fetch_tag + 4'd1;
        else data_tag = data_tag + 4'd1;
        req.op = op;
        req.addr = addr;
        req.byteen = be;
        req.data = wd;
        req.tag = tag;
        if (fetch) {ifetch_req_valid, ifetch_req} = {1'b1, req};
        else {data_req_valid, data_req} = {1'b1, req};
        waited = 0;
        @(negedge clk);
        while (!(fetch ? ifetch_req_ready : data_req_ready)) begin
            @(negedge clk);
            waited++;
            if (waited > LIMIT) fail_msg("request was never accepted");
        end
        @(posedge clk);
        #1;
        if (fetch) ifetch_req_valid = 1'b0;
        else data_req_valid = 1'b0;
    endtask

    task automatic random_data(input int n, input bit any_region);
        logic [31:0] r, a, w;
        for (int i = 0; i < n; i++) begin
            rand_bits(22, a);
            rand_bits(32, w);
            rand_bits(7, r);
            case (any_region ? r[1:0] : 2'd0)
                2'd2:    a = `SMEM_BASE + {26'd0, a[3:0], 2'b00};
                2'd3:    a = `IO_BASE | {8'h00, a[21:0], 2'b00};
                default: a = {8'h20, a[21:0], 2'b00};
            endcase
            issue_req(1'b0, r[2] ? mem_unit_pkg::MEM_WRITE : mem_unit_pkg::MEM_READ, a, r[6:3], w);
        end
    endtask

    task automatic random_fetch(input int n);
        logic [31:0] a;
        for (int i = 0; i < n; i++) begin
            rand_bits(22, a);
            issue_req(1'b1, mem_unit_pkg::MEM_READ, {8'h40, a[21:0], 2'b00}, 4'hF, 32'd0);
        end
    endtask

    initial begin
        logic [31:0] r, w;
        int waited;
        lfsr_state = 32'haac1d2f9;
        {ifetch_req_valid, data_req_valid, io_rsp_valid, dram_rsp_valid} = '0;
        {ifetch_req, data_req, io_rsp, dram_rsp} = '0;
        {ifetch_rsp_ready, data_rsp_ready, io_req_ready, dram_req_ready} = '1;
        {data_tag, fetch_tag, bp, reset} = {4'd0, 4'd0, 1'b0, 1'b1};
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        // Scratchpad fill, partial writes, read back
        for (int i = 0; i < 16; i++) begin
            rand_bits(32, w);
            issue_req(1'b0, mem_unit_pkg::MEM_WRITE, `SMEM_BASE + 32'(i * 4), 4'hF, w);
        end
        for (int i = 0; i < 48; i++) begin
            rand_bits(32, w);
            rand_bits(4, r);
            issue_req(1'b0, i < 24 ? mem_unit_pkg::MEM_WRITE : mem_unit_pkg::MEM_READ,
                      `SMEM_BASE + {26'd0, r[3:0], 2'b00}, w[3:0], w);
        end
        for (int i = 0; i < 20; i++) begin
            rand_bits(32, w);
            issue_req(1'b0, w[31] ? mem_unit_pkg::MEM_WRITE : mem_unit_pkg::MEM_READ,
                      `IO_BASE | {8'h00, w[23:2], 2'b00}, w[3:0], w);
        end
        fork
            random_data(30, 1'b0);
            random_fetch(30);
        join
        bp = 1'b1;
        fork
            random_data(80, 1'b1);
            random_fetch(50);
        join
        bp = 1'b0;

        waited = 0;
        while (data_out.or() || fetch_out.or()) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > LIMIT) fail_msg("reads still outstanding after drain");
        end
        repeat (4) @(posedge clk);
        $display("TB PASSED");
        $finish;
    end

endmodule

/* tb.f */
+incdir+source
source/mem_unit_pkg.sv
source/data_router.sv
source/shared_mem.sv
source/dram_arb.sv
source/dram_perf.sv
source/mem_unit.sv
bench/mem_unit_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert --top-module mem_unit_tb -f tb.f -o mem_unit_sim
./obj_dir/mem_unit_sim
